// File: design/tsc_pkg.sv
package tsc_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths
    localparam int WORD_W    = 16;
    localparam int REG_IDX_W = 2;
    localparam int IMM_W     = 8;
    localparam int NUM_REGS  = 4;

    typedef logic [WORD_W-1:0]    word_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    ////////////////////////////////////////////////////////////////////////////
    // Opcodes and R-type function codes
    localparam logic [3:0] OP_RTYPE = 4'd15;
    localparam logic [3:0] OP_ADI   = 4'd4;
    localparam logic [3:0] OP_ORI   = 4'd5;
    localparam logic [3:0] OP_LHI   = 4'd6;

    localparam logic [5:0] FN_ADD = 6'd0;
    localparam logic [5:0] FN_SUB = 6'd1;
    localparam logic [5:0] FN_AND = 6'd2;
    localparam logic [5:0] FN_ORR = 6'd3;
    localparam logic [5:0] FN_NOT = 6'd4;
    localparam logic [5:0] FN_TCP = 6'd5;
    localparam logic [5:0] FN_SHL = 6'd6;
    localparam logic [5:0] FN_SHR = 6'd7;
    localparam logic [5:0] FN_WWD = 6'd28;
    localparam logic [5:0] FN_HLT = 6'd29;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_ORR,
        ALU_NOT, ALU_TCP, ALU_SHL, ALU_SHR,
        ALU_ADI, ALU_ORI, ALU_LHI, ALU_PASS_A
    } alu_op_t;

    // One instruction word, two views
    typedef union packed {
        struct packed {
            logic [3:0] opcode;
            reg_idx_t   rs;
            reg_idx_t   rt;
            reg_idx_t   rd;
            logic [5:0] funct;
        } r_fmt;
        struct packed {
            logic [3:0]       opcode;
            reg_idx_t         rs;
            reg_idx_t         rt;
            logic [IMM_W-1:0] imm;
        } i_fmt;
    } instr_t;

    ////////////////////////////////////////////////////////////////////////////
    // Pipeline registers
    typedef struct packed {
        logic     valid;
        alu_op_t  alu_op;
        reg_idx_t rs;
        reg_idx_t rt;
        word_t    operand_a;
        word_t    operand_b;
        word_t    imm;        // Already extended
        logic     use_imm;
        reg_idx_t dest;
        logic     reg_write;
        logic     wwd;
        logic     halt;
    } id_ex_t;

    typedef struct packed {
        logic     valid;
        word_t    result;
        reg_idx_t dest;
        logic     reg_write;
        logic     wwd;
        logic     halt;
    } ex_wb_t;

    typedef struct packed {
        logic     we;
        reg_idx_t dest;
        word_t    data;
    } wb_t;

endpackage

// File: design/tsc_regfile.sv
module tsc_regfile #(
    parameter int REG_COUNT = tsc_pkg::NUM_REGS
) (
    input  logic              clk,
    input  logic              reset_n,
    input  tsc_pkg::reg_idx_t rs_idx,
    input  tsc_pkg::reg_idx_t rt_idx,
    input  tsc_pkg::wb_t      wb,
    output tsc_pkg::word_t    rs_data,
    output tsc_pkg::word_t    rt_data
);
    import tsc_pkg::*;

    word_t regs [REG_COUNT];

    // Same-cycle write is passed straight to the reader
    function automatic word_t read_port(input reg_idx_t idx);
        word_t value;
        if (wb.we && wb.dest == idx) begin
            value = wb.data;
        end else begin
            value = regs[idx];
        end
        return value;
    endfunction

    always_comb begin
        rs_data = read_port(rs_idx);
        rt_data = read_port(rt_idx);
    end

    always_ff @(posedge clk) begin
        if (reset_n) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.we) begin
            regs[wb.dest] <= wb.data;
        end
    end

endmodule

// File: design/tsc_decoder.sv
module tsc_decoder (
    input  logic              clk,
    input  logic              reset_n,
    input  logic              inst_valid,
    input  tsc_pkg::instr_t   inst,
    input  logic              kill,
    input  tsc_pkg::word_t    rs_data,
    input  tsc_pkg::word_t    rt_data,
    output tsc_pkg::reg_idx_t rs_idx,
    output tsc_pkg::reg_idx_t rt_idx,
    output tsc_pkg::id_ex_t   id_ex
);
    import tsc_pkg::*;

    id_ex_t dec;

    // rs and rt sit at the same bits in both formats
    assign rs_idx = inst.r_fmt.rs;
    assign rt_idx = inst.r_fmt.rt;

    always_comb begin
        dec           = '0;
        dec.valid     = inst_valid & ~kill;
        dec.alu_op    = ALU_PASS_A;
        dec.rs        = inst.r_fmt.rs;
        dec.rt        = inst.r_fmt.rt;
        dec.operand_a = rs_data;
        dec.operand_b = rt_data;

        if (inst.r_fmt.opcode == OP_RTYPE) begin
            dec.dest      = inst.r_fmt.rd;
            dec.reg_write = 1'b1;
            case (inst.r_fmt.funct)
                FN_ADD:  dec.alu_op = ALU_ADD;
                FN_SUB:  dec.alu_op = ALU_SUB;
                FN_AND:  dec.alu_op = ALU_AND;
                FN_ORR:  dec.alu_op = ALU_ORR;
                FN_NOT:  dec.alu_op = ALU_NOT;
                FN_TCP:  dec.alu_op = ALU_TCP;
                FN_SHL:  dec.alu_op = ALU_SHL;
                FN_SHR:  dec.alu_op = ALU_SHR;
                FN_WWD: begin
                    dec.reg_write = 1'b0;
                    dec.wwd       = 1'b1;
                end
                FN_HLT: begin
                    dec.reg_write = 1'b0;
                    dec.halt      = 1'b1;
                end
                default: dec.reg_write = 1'b0; // Retires as a no-op
            endcase
        end else begin
            dec.dest    = inst.i_fmt.rt;
            dec.use_imm = 1'b1;
            case (inst.i_fmt.opcode)
                OP_ADI: begin
                    dec.alu_op    = ALU_ADI;
                    dec.imm       = {{(WORD_W-IMM_W){inst.i_fmt.imm[IMM_W-1]}}, inst.i_fmt.imm};
                    dec.reg_write = 1'b1;
                end
                OP_ORI: begin
                    dec.alu_op    = ALU_ORI;
                    dec.imm       = {{(WORD_W-IMM_W){1'b0}}, inst.i_fmt.imm};
                    dec.reg_write = 1'b1;
                end
                OP_LHI: begin
                    dec.alu_op    = ALU_LHI;
                    dec.imm       = {inst.i_fmt.imm, {(WORD_W-IMM_W){1'b0}}};
                    dec.reg_write = 1'b1;
                end
                default: dec.use_imm = 1'b0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        id_ex <= dec;
        if (reset_n) begin
            id_ex.valid <= 1'b0;
        end
    end

endmodule

// File: design/tsc_execute.sv
module tsc_execute (
    input  logic            clk,
    input  logic            reset_n,
    input  logic            kill,
    input  tsc_pkg::id_ex_t id_ex,
    output tsc_pkg::ex_wb_t ex_wb
);
    import tsc_pkg::*;

    word_t  fwd_a;
    word_t  fwd_b;
    word_t  alu_b;
    word_t  result;
    logic   wb_live;
    ex_wb_t nxt;

    ////////////////////////////////////////////////////////////////////////////
    // Forwarding from the instruction one ahead
    assign wb_live = ex_wb.valid & ex_wb.reg_write;

    always_comb begin
        fwd_a = id_ex.operand_a;
        fwd_b = id_ex.operand_b;
        if (wb_live && ex_wb.dest == id_ex.rs) begin
            fwd_a = ex_wb.result;
        end
        if (wb_live && ex_wb.dest == id_ex.rt) begin
            fwd_b = ex_wb.result;
        end
    end

    assign alu_b = id_ex.use_imm ? id_ex.imm : fwd_b;

    ////////////////////////////////////////////////////////////////////////////
    // ALU, overflow dropped
    always_comb begin
        case (id_ex.alu_op)
            ALU_ADD,
            ALU_ADI:    result = fwd_a + alu_b;
            ALU_SUB:    result = fwd_a - alu_b;
            ALU_AND:    result = fwd_a & alu_b;
            ALU_ORR,
            ALU_ORI:    result = fwd_a | alu_b;
            ALU_NOT:    result = ~fwd_a;
            ALU_TCP:    result = ~fwd_a + word_t'(1);
            ALU_SHL:    result = fwd_a << 1;
            ALU_SHR:    result = word_t'($signed(fwd_a) >>> 1); // Keeps sign bit
            ALU_LHI:    result = alu_b;
            ALU_PASS_A: result = fwd_a;                         // WWD value
            default:    result = fwd_a;
        endcase
    end

    always_comb begin
        nxt.valid     = id_ex.valid & ~kill;
        nxt.result    = result;
        nxt.dest      = id_ex.dest;
        nxt.reg_write = id_ex.reg_write;
        nxt.wwd       = id_ex.wwd;
        nxt.halt      = id_ex.halt;
    end

    always_ff @(posedge clk) begin
        ex_wb <= nxt;
        if (reset_n) begin
            ex_wb.valid <= 1'b0;
        end
    end

endmodule

// File: design/tsc_pipe_ctrl.sv
module tsc_pipe_ctrl (
    input  logic            clk,
    input  logic            reset_n,
    input  tsc_pkg::ex_wb_t ex_wb,
    output logic            kill,
    output logic            is_halted,
    output tsc_pkg::word_t  num_inst
);
    import tsc_pkg::*;

    typedef enum logic {
        RUN,
        HALTED
    } state_t;

    state_t state;
    state_t state_next;
    logic   halt_retire;

    assign halt_retire = ex_wb.valid & ex_wb.halt;

    always_comb begin
        state_next = state;
        case (state)
            RUN:     if (halt_retire) state_next = HALTED;
            HALTED:  state_next = HALTED;  // Left only by reset
            default: state_next = RUN;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_n) begin
            state <= RUN;
        end else begin
            state <= state_next;
        end
    end

    // Squash everything younger than the HLT
    assign kill      = halt_retire | (state == HALTED);
    assign is_halted = (state == HALTED);

    ////////////////////////////////////////////////////////////////////////////
    // Retired count, HLT included
    always_ff @(posedge clk) begin
        if (reset_n) begin
            num_inst <= '0;
        end else if (ex_wb.valid) begin
            num_inst <= num_inst + word_t'(1);
        end
    end

endmodule

// File: design/tsc_core.sv
module tsc_core #(
    parameter int REG_COUNT = tsc_pkg::NUM_REGS
) (
    input  logic           clk,
    input  logic           reset_n,
    input  logic           inst_valid,
    input  tsc_pkg::word_t inst,
    output logic           out_valid,
    output tsc_pkg::word_t output_port,
    output tsc_pkg::word_t num_inst,
    output logic           is_halted
);
    import tsc_pkg::*;

    reg_idx_t rs_idx;
    reg_idx_t rt_idx;
    word_t    rs_data;
    word_t    rt_data;
    id_ex_t   id_ex;
    ex_wb_t   ex_wb;
    wb_t      wb;
    logic     kill;

    tsc_decoder tsc_decoder_inst (
        .clk        (clk),
        .reset_n    (reset_n),
        .inst_valid (inst_valid),
        .inst       (instr_t'(inst)),
        .kill       (kill),
        .rs_data    (rs_data),
        .rt_data    (rt_data),
        .rs_idx     (rs_idx),
        .rt_idx     (rt_idx),
        .id_ex      (id_ex)
    );

    tsc_regfile #(
        .REG_COUNT (REG_COUNT)
    ) tsc_regfile_inst (
        .clk     (clk),
        .reset_n (reset_n),
        .rs_idx  (rs_idx),
        .rt_idx  (rt_idx),
        .wb      (wb),
        .rs_data (rs_data),
        .rt_data (rt_data)
    );

    tsc_execute tsc_execute_inst (
        .clk     (clk),
        .reset_n (reset_n),
        .kill    (kill),
        .id_ex   (id_ex),
        .ex_wb   (ex_wb)
    );

    tsc_pipe_ctrl tsc_pipe_ctrl_inst (
        .clk       (clk),
        .reset_n   (reset_n),
        .ex_wb     (ex_wb),
        .kill      (kill),
        .is_halted (is_halted),
        .num_inst  (num_inst)
    );

    // Writeback
    assign wb.we   = ex_wb.valid & ex_wb.reg_write;
    assign wb.dest = ex_wb.dest;
    assign wb.data = ex_wb.result;

    ////////////////////////////////////////////////////////////////////////////
    // Output port, loaded when a WWD retires
    always_ff @(posedge clk) begin
        if (reset_n) begin
            out_valid   <= 1'b0;
            output_port <= '0;
        end else begin
            out_valid <= ex_wb.valid & ex_wb.wwd;
            if (ex_wb.valid && ex_wb.wwd) begin
                output_port <= ex_wb.result;
            end
        end
    end

endmodule

// File: tb/tsc_core_asserts.sv
module tsc_core_asserts (
    input logic           clk,
    input logic           reset_n,
    input logic           out_valid,
    input tsc_pkg::word_t num_inst,
    input logic           is_halted
);
    timeunit 1ns;
    timeprecision 100ps;

    // Only reset leaves HALTED
    halt_sticky: assert property (@(posedge clk) disable iff (reset_n)
        is_halted |=> is_halted)
        else $error("is_halted fell while reset was low");

    retire_step: assert property (@(posedge clk) disable iff (reset_n)
        (num_inst == $past(num_inst)) || (num_inst == $past(num_inst) + 16'd1))
        else $error("num_inst moved by more than one in a cycle");

    quiet_when_halted: assert property (@(posedge clk) disable iff (reset_n)
        is_halted |-> !out_valid)
        else $error("out_valid high while the core is halted");

endmodule

bind tsc_core tsc_core_asserts tsc_core_asserts_inst (
    .clk       (clk),
    .reset_n   (reset_n),
    .out_valid (out_valid),
    .num_inst  (num_inst),
    .is_halted (is_halted)
);

// File: tb/tsc_checker.sv
module tsc_checker (
    input logic           clk,
    input logic           reset_n,
    input logic           out_valid,
    input tsc_pkg::word_t output_port,
    input tsc_pkg::word_t num_inst,
    input logic           is_halted
);
    timeunit 1ns;
    timeprecision 100ps;

    import tsc_pkg::*;

    word_t exp_q[$];
    word_t final_count = '0;
    logic  halt_seen   = 1'b0;
    int    out_index   = 0;
    int    error_count = 0;

    function automatic void push_expected(input word_t value);
        exp_q.push_back(value);
    endfunction

    function automatic void set_final_count(input word_t count);
        final_count = count;
    endfunction

    function automatic int outputs_left();
        return exp_q.size();
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Sampled on the falling edge, away from the DUT's register updates
    always @(negedge clk) begin
        word_t expected;
        if (reset_n) begin
            exp_q.delete();
            halt_seen = 1'b0;
            out_index = 0;
        end else begin
            if (out_valid) begin
                if (halt_seen || is_halted) begin
                    $display("** Error at %0t ns: output %h after halt", $time, output_port);
                    error_count++;
                end else if (exp_q.size() == 0) begin
                    $display("** Error at %0t ns: unexpected output %h", $time, output_port);
                    error_count++;
                end else begin
                    expected = exp_q.pop_front();
                    if (output_port !== expected) begin
                        $display("** Error at %0t ns: output %0d is %h, expected %h",
                                 $time, out_index, output_port, expected);
                        error_count++;
                    end
                end
                out_index++;
            end
            if (is_halted && !halt_seen) begin
                halt_seen = 1'b1;
                if (num_inst !== final_count) begin
                    $display("** Error at %0t ns: num_inst is %0d at halt, expected %0d",
                             $time, num_inst, final_count);
                    error_count++;
                end
            end
        end
    end

endmodule

// File: tb/tb_tsc_core.sv
module tb_tsc_core;
    timeunit 1ns;
    timeprecision 100ps;

    import tsc_pkg::*;

    localparam int HALT_TIMEOUT = 300;   // Cycles
    localparam int DRAIN_CYCLES = 4;

    localparam reg_idx_t R0 = 2'd0;
    localparam reg_idx_t R1 = 2'd1;
    localparam reg_idx_t R2 = 2'd2;
    localparam reg_idx_t R3 = 2'd3;

    localparam logic [5:0] ALU_FNS [8] = '{FN_ADD, FN_SUB, FN_AND, FN_ORR,
                                           FN_NOT, FN_TCP, FN_SHL, FN_SHR};
    localparam logic [3:0] IMM_OPS [3] = '{OP_ADI, OP_ORI, OP_LHI};

    logic  clk;
    logic  reset_n;
    logic  inst_valid;
    word_t inst;
    logic  out_valid;
    word_t output_port;
    word_t num_inst;
    logic  is_halted;

    int    seed       = 32'h3f7c;
    int    local_fails = 0;
    int    tests_run   = 0;

    word_t prog[$];
    int    gaps[$];         // Idle cycles after each strobe
    word_t model_out[$];
    word_t model_count;

    initial clk = 1'b0;
    always #20 clk = ~clk;

    tsc_core #(
        .REG_COUNT (NUM_REGS)
    ) tsc_core_inst (
        .clk         (clk),
        .reset_n     (reset_n),
        .inst_valid  (inst_valid),
        .inst        (inst),
        .out_valid   (out_valid),
        .output_port (output_port),
        .num_inst    (num_inst),
        .is_halted   (is_halted)
    );

    tsc_checker tsc_checker_inst (
        .clk         (clk),
        .reset_n     (reset_n),
        .out_valid   (out_valid),
        .output_port (output_port),
        .num_inst    (num_inst),
        .is_halted   (is_halted)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Instruction words
    function automatic word_t rtype_word(input reg_idx_t rs, input reg_idx_t rt,
                                         input reg_idx_t rd, input logic [5:0] fn);
        return {OP_RTYPE, rs, rt, rd, fn};
    endfunction

    function automatic word_t itype_word(input logic [3:0] op, input reg_idx_t rs,
                                         input reg_idx_t rt, input logic [7:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic append_inst(input word_t w, input int gap);
        prog.push_back(w);
        gaps.push_back(gap);
    endtask

    task automatic clear_program();
        prog.delete();
        gaps.delete();
    endtask

    // Sequential model of the instruction set, stops at the first HLT
    function automatic void ref_execute();
        word_t      regs [NUM_REGS];
        word_t      a;
        word_t      b;
        logic [3:0] op;
        logic [5:0] fn;
        reg_idx_t   rs;
        reg_idx_t   rt;
        reg_idx_t   rd;
        logic [7:0] imm;
        model_out.delete();
        model_count = '0;
        for (int i = 0; i < NUM_REGS; i++) begin
            regs[i] = '0;
        end
        foreach (prog[i]) begin
            op  = prog[i][15:12];
            rs  = prog[i][11:10];
            rt  = prog[i][9:8];
            rd  = prog[i][7:6];
            fn  = prog[i][5:0];
            imm = prog[i][7:0];
            a   = regs[rs];
            b   = regs[rt];
            model_count = model_count + 16'd1;
            if (op == OP_RTYPE) begin
                case (fn)
                    FN_ADD:  regs[rd] = a + b;
                    FN_SUB:  regs[rd] = a - b;
                    FN_AND:  regs[rd] = a & b;
                    FN_ORR:  regs[rd] = a | b;
                    FN_NOT:  regs[rd] = ~a;
                    FN_TCP:  regs[rd] = 16'd0 - a;
                    FN_SHL:  regs[rd] = {a[14:0], 1'b0};
                    FN_SHR:  regs[rd] = {a[15], a[15:1]};
                    FN_WWD:  model_out.push_back(a);
                    FN_HLT:  return;
                    default: ;
                endcase
            end else if (op == OP_ADI) begin
                regs[rt] = a + {{8{imm[7]}}, imm};
            end else if (op == OP_ORI) begin
                regs[rt] = a | {8'h00, imm};
            end else if (op == OP_LHI) begin
                regs[rt] = {imm, 8'h00};
            end
        end
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Programs
    task automatic alu_program();
        clear_program();
        append_inst(itype_word(OP_LHI, R0, R0, 8'h12), 3);
        append_inst(itype_word(OP_ORI, R0, R0, 8'h34), 3);
        append_inst(itype_word(OP_LHI, R1, R1, 8'hf0), 3);
        append_inst(itype_word(OP_ORI, R1, R1, 8'h0f), 3);
        for (int i = 0; i < 8; i++) begin
            append_inst(rtype_word(R1, R0, R2, ALU_FNS[i]), 3);
            append_inst(rtype_word(R2, R0, R0, FN_WWD), 3);
        end
        append_inst(rtype_word(R0, R0, R0, FN_HLT), 0);
    endtask

    task automatic immediate_program();
        clear_program();
        append_inst(itype_word(OP_ADI, R0, R0, 8'hfb), 2);   // -5
        append_inst(rtype_word(R0, R0, R0, FN_WWD), 2);
        append_inst(itype_word(OP_ADI, R1, R1, 8'h64), 2);
        append_inst(rtype_word(R1, R0, R0, FN_WWD), 2);
        append_inst(itype_word(OP_ORI, R2, R2, 8'h80), 2);   // Top bit set
        append_inst(rtype_word(R2, R0, R0, FN_WWD), 2);
        append_inst(itype_word(OP_ADI, R2, R3, 8'h80), 2);
        append_inst(rtype_word(R3, R0, R0, FN_WWD), 2);
        append_inst(itype_word(OP_ORI, R3, R3, 8'hff), 2);
        append_inst(rtype_word(R3, R0, R0, FN_WWD), 2);
        append_inst(rtype_word(R0, R0, R0, FN_HLT), 0);
    endtask

    task automatic hazard_program();
        clear_program();
        append_inst(itype_word(OP_LHI, R0, R0, 8'h01), 0);
        append_inst(itype_word(OP_ADI, R0, R0, 8'h05), 0);
        append_inst(itype_word(OP_ADI, R0, R1, 8'h03), 0);
        append_inst(rtype_word(R0, R1, R2, FN_ADD), 0);
        append_inst(rtype_word(R2, R0, R0, FN_WWD), 0);
        append_inst(rtype_word(R2, R0, R3, FN_SUB), 0);
        append_inst(itype_word(OP_ORI, R1, R1, 8'h40), 0);
        append_inst(rtype_word(R3, R0, R0, FN_WWD), 0);
        append_inst(rtype_word(R1, R0, R0, FN_SHL), 0);
        append_inst(rtype_word(R0, R0, R0, FN_WWD), 0);
        append_inst(rtype_word(R0, R0, R0, FN_TCP), 0);
        append_inst(rtype_word(R0, R0, R0, FN_WWD), 0);
        append_inst(rtype_word(R0, R0, R0, FN_HLT), 0);
    endtask

    task automatic random_program(input int length);
        word_t r;
        int    kind;
        int    gap;
        clear_program();
        for (int i = 0; i < length; i++) begin
            r    = word_t'($random(seed));
            kind = $unsigned($random(seed)) % 13;
            gap  = $unsigned($random(seed)) % 3;
            if (kind < 8) begin
                append_inst(rtype_word(r[11:10], r[9:8], r[7:6], ALU_FNS[kind]), gap);
            end else if (kind < 11) begin
                append_inst(itype_word(IMM_OPS[kind - 8], r[11:10], r[9:8], r[7:0]), gap);
            end else begin
                append_inst(rtype_word(r[11:10], r[9:8], R0, FN_WWD), gap);
            end
        end
        append_inst(rtype_word(R0, R0, R0, FN_HLT), 0);
    endtask

    task automatic halt_program();
        clear_program();
        append_inst(itype_word(OP_LHI, R0, R0, 8'h5a), 1);
        append_inst(rtype_word(R0, R0, R0, FN_WWD), 0);
        append_inst(rtype_word(R0, R0, R0, FN_HLT), 0);
        append_inst(rtype_word(R0, R0, R0, FN_WWD), 0);   // Must be squashed
        append_inst(itype_word(OP_ADI, R1, R1, 8'h01), 1);
        append_inst(rtype_word(R1, R0, R0, FN_WWD), 0);
        append_inst(rtype_word(R0, R0, R0, FN_WWD), 2);
        append_inst(rtype_word(R0, R0, R0, FN_HLT), 0);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Driving and sequencing
    task automatic apply_reset();
        @(posedge clk);
        #2;
        reset_n    = 1'b1;
        inst_valid = 1'b0;
        repeat (3) @(posedge clk);
        #2;
        reset_n = 1'b0;
    endtask

    task automatic send_program();
        foreach (prog[i]) begin
            @(posedge clk);
            #2;
            inst_valid = 1'b1;
            inst       = prog[i];
            for (int g = 0; g < gaps[i]; g++) begin
                @(posedge clk);
                #2;
                inst_valid = 1'b0;
            end
        end
        @(posedge clk);
        #2;
        inst_valid = 1'b0;
    endtask

    task automatic wait_halted();
        int cycles;
        cycles = 0;
        while (!is_halted && cycles < HALT_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!is_halted) begin
            $display("Timeout: the core did not halt within %0d cycles", HALT_TIMEOUT);
            local_fails++;
        end
    endtask

    task automatic run_test(input string name);
        int errors_before;
        int left;
        int new_errors;
        errors_before = tsc_checker_inst.error_count + local_fails;
        apply_reset();
        ref_execute();
        foreach (model_out[i]) begin
            tsc_checker_inst.push_expected(model_out[i]);
        end
        tsc_checker_inst.set_final_count(model_count);
        send_program();
        wait_halted();
        repeat (DRAIN_CYCLES) @(negedge clk);   // Room for any stray output
        left = tsc_checker_inst.outputs_left();
        if (left != 0) begin
            $display("Test %s: %0d expected outputs never appeared", name, left);
            local_fails++;
        end
        tests_run++;
        new_errors = tsc_checker_inst.error_count + local_fails - errors_before;
        $display("Test %0d (%s) finished with %0d errors", tests_run, name, new_errors);
    endtask

    initial begin
        int total;
        reset_n    = 1'b1;
        inst_valid = 1'b0;
        inst       = '0;

        alu_program();
        run_test("alu ops");
        immediate_program();
        run_test("immediates");
        hazard_program();
        run_test("forwarding");
        for (int n = 0; n < 3; n++) begin
            random_program(40);
            run_test("random");
        end
        halt_program();
        run_test("halt");

        total = tsc_checker_inst.error_count + local_fails;
        $display("%0d tests run, %0d errors", tests_run, total);
        if (total == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: sources.f
design/tsc_pkg.sv
design/tsc_regfile.sv
design/tsc_decoder.sv
design/tsc_execute.sv
design/tsc_pipe_ctrl.sv
design/tsc_core.sv
tb/tsc_core_asserts.sv
tb/tsc_checker.sv
tb/tb_tsc_core.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and scan the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=sim_tsc_core

rm -f "$LOG"

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_tsc_core -f sources.f -o "$BIN"
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q ">>> FAIL" "$LOG"; then
    echo "Simulation reported failure"
    exit 1
fi

echo "Simulation finished without failure"
exit 0
